/* verilog/ahb_config.svh */
`ifndef AHB_CONFIG_SVH
`define AHB_CONFIG_SVH

// bus widths
`define AHB_ADDR_W 32
`define AHB_DATA_W 32

// two master ports on the fabric
`define NUM_MASTERS 2

// address map, top nibble of haddr
`define RAM_REGION 4'h0
`define GPIO_REGION 4'h1

// ram depth in 32-bit words
`define RAM_WORDS 256

// gpio widths
`define GPIO_PIN_W 2
`define LED_W 4

`endif

/* verilog/ahbPkg.sv */
`include "ahb_config.svh"

package ahbPkg;

  // htrans, only the two codes this fabric uses
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    NONSEQ = 2'b10
  } transT;

  // hresp, no split/retry here
  typedef enum logic {
    OKAY  = 1'b0,
    ERROR = 1'b1
  } respT;

  // master side, address phase fields plus write data
  typedef struct packed {
    logic [`AHB_ADDR_W-1:0] haddr;
    transT                  trans;
    logic                   hwrite;
    logic [`AHB_DATA_W-1:0] hwdata; // data phase, one cycle behind haddr
  } ahbReqT;

  // slave side response
  typedef struct packed {
    logic [`AHB_DATA_W-1:0] hrdata;
    logic                   hready; // low = wait state
    respT                   hresp;
  } ahbRespT;

endpackage

/* verilog/fabricPkg.sv */
package fabricPkg;

  // which slave owns a transfer
  // SEL_NONE marks a data phase with no transfer in it
  typedef enum logic [1:0] {
    SEL_RAM     = 2'd0,
    SEL_GPIO    = 2'd1,
    SEL_DEFAULT = 2'd2,
    SEL_NONE    = 2'd3
  } slaveSelT;

  // default slave error response, two data cycles
  typedef enum logic {
    ERR_IDLE   = 1'b0, // first cycle, hready low
    ERR_SECOND = 1'b1  // second cycle, hready high
  } errStateT;

endpackage

/* verilog/ahbArbiter.sv */
`timescale 1ns/1ps
`include "ahb_config.svh"

module ahbArbiter (
  input  logic                      HCLK,
  input  logic                      rstN,
  input  logic [`NUM_MASTERS-1:0]   busReq,
  input  ahbPkg::ahbReqT            mReq [`NUM_MASTERS],
  input  logic                      hready,
  output logic [`NUM_MASTERS-1:0]   grant,
  output ahbPkg::ahbReqT            addrReq,
  output logic [`AHB_DATA_W-1:0]    dataWdata
);

  localparam int NumM = `NUM_MASTERS;
  localparam int IdxW = (NumM > 1) ? $clog2(NumM) : 1;

  logic [IdxW-1:0] ownerIdx;  // current / last granted master
  logic [IdxW-1:0] nextIdx;
  logic            nextFound;
  logic [IdxW-1:0] dataOwner; // master whose transfer is in data phase

  // round robin search, starting just after the last owner
  // the last owner itself is checked last so a lone requester keeps the bus
  always_comb begin : pickNext
    int cand;
    nextIdx   = ownerIdx;
    nextFound = 1'b0;
    for (int i = 1; i <= NumM; i++) begin
      cand = (int'(ownerIdx) + i) % NumM;
      if (!nextFound && busReq[cand]) begin
        nextIdx   = IdxW'(cand);
        nextFound = 1'b1;
      end
    end
  end

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      ownerIdx  <= IdxW'(NumM - 1); // so master 0 is first in line
      grant     <= '0;
      dataOwner <= '0;
    end else if (hready) begin      // nothing moves under a wait state
      if (nextFound) begin
        ownerIdx <= nextIdx;
        grant    <= NumM'(1) << nextIdx;
      end
      // remember who owns the accepted address phase
      if (addrReq.trans == ahbPkg::NONSEQ) begin
        dataOwner <= ownerIdx;
      end
    end
  end

  // address phase mux, idle bus when nobody holds the grant
  always_comb begin
    if (grant[ownerIdx]) begin
      addrReq = mReq[ownerIdx];
    end else begin
      addrReq       = '0;
      addrReq.trans = ahbPkg::IDLE;
    end
  end

  // wdata follows the data phase owner, not the current grant
  assign dataWdata = mReq[dataOwner].hwdata;

endmodule

/* verilog/ahbDecoder.sv */
`timescale 1ns/1ps
`include "ahb_config.svh"

module ahbDecoder (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  ahbPkg::ahbReqT       addrReq,
  input  logic                 hready,
  output fabricPkg::slaveSelT  slaveSel,
  output fabricPkg::slaveSelT  dataSel
);

  logic [3:0] region;

  assign region = addrReq.haddr[`AHB_ADDR_W-1 -: 4]; // top nibble picks the slave

  always_comb begin
    case (region)
      `RAM_REGION:  slaveSel = fabricPkg::SEL_RAM;
      `GPIO_REGION: slaveSel = fabricPkg::SEL_GPIO;
      default:      slaveSel = fabricPkg::SEL_DEFAULT; // unmapped
    endcase
  end

  // data phase select, moves only when the bus is ready
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      dataSel <= fabricPkg::SEL_NONE;
    end else if (hready) begin
      if (addrReq.trans == ahbPkg::NONSEQ) begin
        dataSel <= slaveSel;
      end else begin
        dataSel <= fabricPkg::SEL_NONE; // idle cycle, empty data phase
      end
    end
  end

endmodule

/* verilog/ramSlave.sv */
`timescale 1ns/1ps
`include "ahb_config.svh"

module ramSlave (
  input  logic                    HCLK,
  input  logic                    rstN,
  input  ahbPkg::ahbReqT          addrReq,
  input  logic                    sel,
  input  logic                    hreadyIn,
  input  logic [`AHB_DATA_W-1:0]  wdata,
  output ahbPkg::ahbRespT         resp
);

  localparam int AddrW = $clog2(`RAM_WORDS);

  logic [`AHB_DATA_W-1:0] mem [`RAM_WORDS];
  logic                   accept;
  logic                   dActive;   // data phase in progress
  logic                   readReady; // wait cycle done, rdData valid
  logic                   dWrite;
  logic [AddrW-1:0]       dAddr;     // word index
  logic [`AHB_DATA_W-1:0] rdData;

  assign accept = sel && hreadyIn && (addrReq.trans == ahbPkg::NONSEQ);

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      dActive   <= 1'b0;
      readReady <= 1'b0;
    end else if (hreadyIn) begin
      dActive   <= accept; // back to back transfers keep it set
      readReady <= 1'b0;
    end else if (dActive && !dWrite) begin
      readReady <= 1'b1;   // end of the single read wait state
    end
  end

  always_ff @(posedge HCLK) begin
    if (accept) begin
      dAddr  <= addrReq.haddr[2 +: AddrW];
      dWrite <= addrReq.hwrite;
    end
    // write lands at the end of its zero wait data phase
    if (dActive && dWrite && hreadyIn) begin
      mem[dAddr] <= wdata;
    end
    // read fetched during the wait cycle
    if (dActive && !dWrite && !readReady) begin
      rdData <= mem[dAddr];
    end
  end

  assign resp.hrdata = rdData;
  assign resp.hready = !(dActive && !dWrite && !readReady); // low once per read
  assign resp.hresp  = ahbPkg::OKAY;

endmodule

/* verilog/gpioSlave.sv */
`timescale 1ns/1ps
`include "ahb_config.svh"

module gpioSlave (
  input  logic                    HCLK,
  input  logic                    rstN,
  input  ahbPkg::ahbReqT          addrReq,
  input  logic                    sel,
  input  logic                    hreadyIn,
  input  logic [`AHB_DATA_W-1:0]  wdata,
  input  logic [`GPIO_PIN_W-1:0]  ioPin,
  output logic [`LED_W-1:0]       led,
  output ahbPkg::ahbRespT         resp
);

  logic                   accept;
  logic                   dActive;
  logic                   dWrite;
  logic                   dLedReg; // offset 4 selected
  logic [`GPIO_PIN_W-1:0] pinReg;  // sampled pins
  logic [`LED_W-1:0]      ledReg;

  assign accept = sel && hreadyIn && (addrReq.trans == ahbPkg::NONSEQ);

  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      dActive <= 1'b0;
      ledReg  <= '0;
    end else if (hreadyIn) begin
      dActive <= accept;
      if (dActive && dWrite && dLedReg) begin
        ledReg <= wdata[`LED_W-1:0]; // pin register ignores writes
      end
    end
  end

  always_ff @(posedge HCLK) begin
    pinReg <= ioPin;
    if (accept) begin
      dWrite  <= addrReq.hwrite;
      dLedReg <= addrReq.haddr[2];
    end
  end

  // zero wait, read data straight from the registers
  assign resp.hrdata = dLedReg ? {{(`AHB_DATA_W-`LED_W){1'b0}}, ledReg}
                               : {{(`AHB_DATA_W-`GPIO_PIN_W){1'b0}}, pinReg};
  assign resp.hready = 1'b1;
  assign resp.hresp  = ahbPkg::OKAY;

  assign led = ledReg;

endmodule

/* verilog/responseMux.sv */
`timescale 1ns/1ps
`include "ahb_config.svh"

module responseMux (
  input  logic                 HCLK,
  input  logic                 rstN,
  input  fabricPkg::slaveSelT  dataSel,
  input  ahbPkg::ahbRespT      ramResp,
  input  ahbPkg::ahbRespT      gpioResp,
  output ahbPkg::ahbRespT      bus
);

  fabricPkg::errStateT errState;

  // default slave, dataSel holds through the low cycle so this toggles once
  always_ff @(posedge HCLK or negedge rstN) begin
    if (!rstN) begin
      errState <= fabricPkg::ERR_IDLE;
    end else if (dataSel == fabricPkg::SEL_DEFAULT && errState == fabricPkg::ERR_IDLE) begin
      errState <= fabricPkg::ERR_SECOND;
    end else begin
      errState <= fabricPkg::ERR_IDLE; // back to back errors restart here
    end
  end

  always_comb begin
    case (dataSel)
      fabricPkg::SEL_RAM:  bus = ramResp;
      fabricPkg::SEL_GPIO: bus = gpioResp;
      fabricPkg::SEL_DEFAULT: begin
        bus.hrdata = '0;
        bus.hready = (errState == fabricPkg::ERR_SECOND); // low, then high
        bus.hresp  = ahbPkg::ERROR;
      end
      default: begin // empty data phase
        bus.hrdata = '0;
        bus.hready = 1'b1;
        bus.hresp  = ahbPkg::OKAY;
      end
    endcase
  end

endmodule

/* verilog/ahbFabricTop.sv */
`timescale 1ns/1ps
`include "ahb_config.svh"

module ahbFabricTop (
  input  logic                    HCLK,
  input  logic                    rstN,
  input  logic [`NUM_MASTERS-1:0] busReq,
  input  ahbPkg::ahbReqT          mReq [`NUM_MASTERS],
  input  logic [`GPIO_PIN_W-1:0]  ioPin,
  output logic [`NUM_MASTERS-1:0] grant,
  output ahbPkg::ahbRespT         bus,
  output logic [`LED_W-1:0]       led
);

  ahbPkg::ahbReqT         addrReq;   // granted address phase
  logic [`AHB_DATA_W-1:0] dataWdata; // data phase owner's hwdata
  fabricPkg::slaveSelT    slaveSel;
  fabricPkg::slaveSelT    dataSel;
  ahbPkg::ahbRespT        ramResp;
  ahbPkg::ahbRespT        gpioResp;

  ahbArbiter arb0 (
    .HCLK      (HCLK),
    .rstN      (rstN),
    .busReq    (busReq),
    .mReq      (mReq),
    .hready    (bus.hready),
    .grant     (grant),
    .addrReq   (addrReq),
    .dataWdata (dataWdata)
  );

  ahbDecoder dec0 (
    .HCLK     (HCLK),
    .rstN     (rstN),
    .addrReq  (addrReq),
    .hready   (bus.hready),
    .slaveSel (slaveSel),
    .dataSel  (dataSel)
  );

  ramSlave ram0 (
    .HCLK     (HCLK),
    .rstN     (rstN),
    .addrReq  (addrReq),
    .sel      (slaveSel == fabricPkg::SEL_RAM),
    .hreadyIn (bus.hready),
    .wdata    (dataWdata),
    .resp     (ramResp)
  );

  gpioSlave gpio0 (
    .HCLK     (HCLK),
    .rstN     (rstN),
    .addrReq  (addrReq),
    .sel      (slaveSel == fabricPkg::SEL_GPIO),
    .hreadyIn (bus.hready),
    .wdata    (dataWdata),
    .ioPin    (ioPin),
    .led      (led),
    .resp     (gpioResp)
  );

  // also hosts the default slave for unmapped addresses
  responseMux rmux0 (
    .HCLK     (HCLK),
    .rstN     (rstN),
    .dataSel  (dataSel),
    .ramResp  (ramResp),
    .gpioResp (gpioResp),
    .bus      (bus)
  );

endmodule

/* test/ahbFabricTb.sv */
`timescale 1ns/1ps
`include "ahb_config.svh"

module ahbFabricTb;

  localparam int MaxWait = 40; // cycles allowed per wait loop

  logic                    HCLK;
  logic                    rstN;
  logic [`NUM_MASTERS-1:0] busReq;
  ahbPkg::ahbReqT          mReq [`NUM_MASTERS];
  logic [`GPIO_PIN_W-1:0]  ioPin;
  logic [`NUM_MASTERS-1:0] grant;
  ahbPkg::ahbRespT         bus;
  logic [`LED_W-1:0]       led;

  logic [`AHB_DATA_W-1:0]  ramModel [`RAM_WORDS]; // words written so far
  logic [`LED_W-1:0]       ledModel;
  logic [15:0]             lfsr;
  int                      lastOwner; // master holding the grant, -1 before any transfer
  int                      errors;
  int                      timeouts;
  int                      transfers;

  ahbFabricTop dut0 (
    .HCLK   (HCLK),
    .rstN   (rstN),
    .busReq (busReq),
    .mReq   (mReq),
    .ioPin  (ioPin),
    .grant  (grant),
    .bus    (bus),
    .led    (led)
  );

  always #10 HCLK = ~HCLK; // 20 ns period

  // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  // expected read data from the address map
  function automatic logic [31:0] expectRead(input logic [31:0] addr, input logic [31:0] pins);
    if (addr[31:28] == `RAM_REGION) begin
      return ramModel[addr[2 +: $clog2(`RAM_WORDS)]];
    end
    if (addr[2]) begin
      return 32'(ledModel); // offset 4
    end
    return pins & ((32'd1 << `GPIO_PIN_W) - 1); // pins zero extended
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    errors++;
    $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expVal, actVal);
  endtask

  // one transfer from one master checked against the reference model
  task automatic runTransfer(input int m, input logic wr, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [31:0] pins,
                             input string expTok);
    int          n;
    int          code;
    int          waits;
    int          expWaits;
    logic        ready;
    logic        firstResp;
    logic        expErr;
    logic        ramHit;
    logic [31:0] expData;
    expErr   = (expTok == "ERROR");
    ramHit   = (addr[31:28] == `RAM_REGION);
    expData  = expectRead(addr, pins);
    if (!expErr && expTok != "OKAY") begin
      code = $sscanf(expTok, "%h", expData); // explicit rdata
    end
    expWaits = (expErr || (ramHit && !wr)) ? 1 : 0; // ram read and default slave wait once
    @(posedge HCLK);
    #1;
    ioPin          = pins[`GPIO_PIN_W-1:0];
    busReq[m]      = 1'b1;
    mReq[m].haddr  = addr;
    mReq[m].trans  = ahbPkg::NONSEQ;
    mReq[m].hwrite = wr;
    ready = 1'b0;
    n     = 0;
    while (!ready && n < MaxWait) begin
      @(negedge HCLK);
      ready = grant[m] && bus.hready; // taken at the coming edge
      n++;
    end
    if (!ready) begin
      $display("timeout: master %0d never got the bus for address %h", m, addr);
      timeouts++;
      busReq[m]     = 1'b0;
      mReq[m].trans = ahbPkg::IDLE;
      return;
    end
    @(posedge HCLK); // address phase accepted
    #1;
    lastOwner      = m;
    mReq[m].trans  = ahbPkg::IDLE;
    mReq[m].hwdata = wdata;
    ready     = 1'b0;
    n         = 0;
    waits     = 0;
    firstResp = 1'b0;
    while (!ready && n < MaxWait) begin
      @(negedge HCLK);
      ready = bus.hready;
      if (!ready) begin
        if (waits == 0) firstResp = bus.hresp;
        waits++;
      end
      n++;
    end
    if (!ready) begin
      $display("timeout: data phase at address %h never finished", addr);
      timeouts++;
      busReq[m] = 1'b0;
      return;
    end
    transfers++;
    if (bus.hresp !== (expErr ? ahbPkg::ERROR : ahbPkg::OKAY)) begin
      reportMismatch("bus.hresp", expErr, bus.hresp);
    end
    if (waits != expWaits) reportMismatch("bus.hready low cycles", expWaits, waits);
    if (expErr && firstResp !== ahbPkg::ERROR) begin
      reportMismatch("bus.hresp first cycle", 1, firstResp);
    end
    if (!wr && !expErr && bus.hrdata !== expData) begin
      reportMismatch("bus.hrdata", expData, bus.hrdata);
    end
    if (grant !== (`NUM_MASTERS'(1) << m)) begin // lone requester keeps it
      reportMismatch("grant", `NUM_MASTERS'(1) << m, grant);
    end
    if (wr && !expErr) begin
      if (ramHit) ramModel[addr[2 +: $clog2(`RAM_WORDS)]] = wdata;
      else if (addr[2]) ledModel = wdata[`LED_W-1:0];
    end
    @(posedge HCLK); // data phase ends
    #1;
    busReq[m] = 1'b0;
    @(negedge HCLK);
    if (led !== ledModel) reportMismatch("led", ledModel, led);
  endtask

  // masters 0 and 1 write ram back to back while the grant alternates
  task automatic backToBackWrites(input logic [31:0] addr, input logic [31:0] wdata0);
    logic [31:0]             pData [2];
    logic [31:0]             pAddr [2];
    logic [`NUM_MASTERS-1:0] expGrant;
    int                      cur;
    int                      nAcc;
    int                      n;
    int                      accK;
    logic                    fin;
    pAddr[0] = addr;
    pAddr[1] = addr + 32'd4;
    pData[0] = wdata0;
    pData[1] = randBits(32);
    cur      = lastOwner; // grant stays put while nobody requests
    @(posedge HCLK);
    #1;
    for (int i = 0; i < 2; i++) begin
      mReq[i].haddr  = pAddr[i];
      mReq[i].trans  = ahbPkg::NONSEQ;
      mReq[i].hwrite = 1'b1;
    end
    busReq = 2'b11; // both keep requesting
    nAcc = 0;
    n    = 0;
    fin  = 1'b0;
    while (!fin && n < MaxWait) begin
      @(negedge HCLK);
      n++;
      accK     = -1;
      expGrant = (cur < 0) ? '0 : (`NUM_MASTERS'(1) << cur);
      if (grant !== expGrant) reportMismatch("grant", expGrant, grant);
      if (bus.hresp !== ahbPkg::OKAY) reportMismatch("bus.hresp", 0, bus.hresp);
      if (bus.hready && nAcc == 2) begin
        fin = 1'b1; // second data phase ends at the next edge
      end else if (bus.hready && cur < 0) begin
        cur = 0; // first grant after reset goes to master 0
      end else if (bus.hready) begin
        accK = cur; // granted address phase taken at the edge
      end
      @(posedge HCLK);
      #1;
      if (accK >= 0) begin
        mReq[accK].trans  = ahbPkg::IDLE;
        mReq[accK].hwdata = pData[accK]; // owner's data for its data phase
        nAcc++;
        cur = 1 - accK; // the other master is next in line
      end
    end
    busReq = '0;
    if (!fin) begin
      $display("timeout: back to back writes at %h did not both finish", addr);
      timeouts++;
      for (int i = 0; i < 2; i++) mReq[i].trans = ahbPkg::IDLE;
      return;
    end
    lastOwner = 1 - cur; // both still requested at the last edge
    transfers += 2;
    for (int i = 0; i < 2; i++) ramModel[pAddr[i][2 +: $clog2(`RAM_WORDS)]] = pData[i];
  endtask

  initial begin : mainFlow
    int          fd;
    int          code;
    int          m;
    int          w;
    logic        more;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] pinVal;
    string       opTok;
    string       wTok;
    string       pTok;
    string       eTok;
    string       rest;
    HCLK      = 1'b0;
    rstN      = 1'b0;
    busReq    = '0;
    ioPin     = '0;
    ledModel  = '0;
    lfsr      = 16'd7972;
    lastOwner = -1;
    errors    = 0;
    timeouts  = 0;
    transfers = 0;
    for (int i = 0; i < `NUM_MASTERS; i++) begin
      mReq[i]       = '0;
      mReq[i].trans = ahbPkg::IDLE;
    end
    repeat (16) @(posedge HCLK);
    #1;
    rstN = 1'b1;
    @(negedge HCLK);
    if (grant !== '0) reportMismatch("grant", 0, grant);
    if (bus.hready !== 1'b1) reportMismatch("bus.hready", 1, bus.hready);
    if (bus.hresp !== ahbPkg::OKAY) reportMismatch("bus.hresp", 0, bus.hresp);
    if (led !== '0) reportMismatch("led", 0, led);
    fd = $fopen("test/bus_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open test/bus_vectors.txt");
      errors++;
    end else begin
      more = 1'b1;
      while (more) begin
        code = $fscanf(fd, " %s", opTok);
        if (code != 1) begin
          more = 1'b0; // end of file
        end else if (opTok.getc(0) == "#") begin
          code = $fgets(rest, fd); // comment line
        end else begin
          code = $fscanf(fd, " %d %d %h %s %s %s", m, w, addr, wTok, pTok, eTok);
          if (code != 6) begin
            $display("vector line starting with %s is malformed", opTok);
            errors++;
            more = 1'b0;
          end else begin
            if (wTok == "rnd") wdata = randBits(32);
            else code = $sscanf(wTok, "%h", wdata);
            if (pTok == "rnd") pinVal = randBits(`GPIO_PIN_W);
            else code = $sscanf(pTok, "%h", pinVal);
            if (opTok == "P") backToBackWrites(addr, wdata);
            else runTransfer(m, w[0], addr, wdata, pinVal, eTok);
          end
        end
      end
      $fclose(fd);
    end
    $display("transfers %0d, errors %0d, timeouts %0d", transfers, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* test/bus_vectors.txt */
# op master write addr wdata pin expect  (wdata and pin may be rnd, expect OKAY ERROR or rdata)
# op T runs one transfer, op P has masters 0 and 1 write addr and addr+4 back to back
T 0 1 00000010 deadbeef 0 OKAY
T 0 0 00000010 0 0 OKAY
T 1 1 00000024 rnd 0 OKAY
T 1 0 00000024 0 0 OKAY
T 1 0 00000010 0 0 deadbeef
T 0 0 10000000 0 2 OKAY
T 1 0 10000000 0 rnd OKAY
T 0 0 10000000 0 1 00000001
T 0 1 10000004 0000003a 0 OKAY
T 0 0 10000004 0 0 0000000a
T 1 1 10000004 rnd 3 OKAY
T 1 0 10000004 0 3 OKAY
T 0 1 10000000 ffffffff 0 OKAY
T 0 0 10000000 0 rnd OKAY
T 0 0 20000000 0 0 ERROR
T 1 1 30000040 12345678 1 ERROR
T 0 0 f0000000 0 0 ERROR
T 0 1 000003fc rnd 0 OKAY
T 0 0 000003fc 0 0 OKAY
P 0 1 00000100 a5a5a5a5 0 OKAY
T 1 0 00000100 0 0 a5a5a5a5
T 0 0 00000104 0 0 OKAY
P 0 1 00000200 0badc0de 0 OKAY
T 1 0 00000200 0 0 0badc0de
T 0 0 00000204 0 0 OKAY

/* src.f */
+incdir+verilog
verilog/ahbPkg.sv
verilog/fabricPkg.sv
verilog/ahbArbiter.sv
verilog/ahbDecoder.sv
verilog/ramSlave.sv
verilog/gpioSlave.sv
verilog/responseMux.sv
verilog/ahbFabricTop.sv
test/ahbFabricTb.sv

/* Bender.yml */
package:
  name: ahb_fabric

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ahbPkg.sv
      - verilog/fabricPkg.sv
      - verilog/ahbArbiter.sv
      - verilog/ahbDecoder.sv
      - verilog/ramSlave.sv
      - verilog/gpioSlave.sv
      - verilog/responseMux.sv
      - verilog/ahbFabricTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/ahbFabricTb.sv
